//--- source/tomasuloPkg.sv
`default_nettype none

package tomasuloPkg;

    localparam int dataWidth = 32;
    localparam int regWidth = 5;
    localparam int robDepth = 8;
    localparam int robIdxWidth = 3;
    localparam int tagWidth = 4;
    localparam int stationDepth = 4;
    localparam int stationIdxWidth = 2;
    localparam int aluOpWidth = 4;

    // value present, no producer pending
    localparam logic [tagWidth-1:0] tagFree = '0;

    localparam logic [aluOpWidth-1:0] opAdd = 4'd0;
    localparam logic [aluOpWidth-1:0] opSub = 4'd1;
    localparam logic [aluOpWidth-1:0] opSll = 4'd2;
    localparam logic [aluOpWidth-1:0] opSlt = 4'd3;
    localparam logic [aluOpWidth-1:0] opSltu = 4'd4;
    localparam logic [aluOpWidth-1:0] opXor = 4'd5;
    localparam logic [aluOpWidth-1:0] opSrl = 4'd6;
    localparam logic [aluOpWidth-1:0] opSra = 4'd7;
    localparam logic [aluOpWidth-1:0] opOr = 4'd8;
    localparam logic [aluOpWidth-1:0] opAnd = 4'd9;

    localparam logic [6:0] classRI = 7'b0010011;
    localparam logic [6:0] classRR = 7'b0110011;

    // addi x0, x0, 0
    localparam logic [31:0] nopInst = 32'h0000_0013;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [regWidth-1:0] rs2;
            logic [regWidth-1:0] rs1;
            logic [2:0] funct3;
            logic [regWidth-1:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [regWidth-1:0] rs1;
            logic [2:0] funct3;
            logic [regWidth-1:0] rd;
            logic [6:0] opcode;
        } iType;
    } instWord;

endpackage

`default_nettype wire

//--- source/dispatchIf.sv
`timescale 1ns/1ps
`default_nettype none

interface dispatchIf;

    logic valid;
    logic [tomasuloPkg::tagWidth-1:0] destTag;
    logic [tomasuloPkg::aluOpWidth-1:0] op;
    logic [tomasuloPkg::tagWidth-1:0] tag1;
    logic [tomasuloPkg::dataWidth-1:0] data1;
    logic [tomasuloPkg::tagWidth-1:0] tag2;
    logic [tomasuloPkg::dataWidth-1:0] data2;

    modport decoder (output valid, destTag, op, tag1, data1, tag2, data2);

    modport station (input valid, destTag, op, tag1, data1, tag2, data2);

endinterface

`default_nettype wire

//--- source/cdbIf.sv
`timescale 1ns/1ps
`default_nettype none

interface cdbIf;

    logic valid;
    logic [tomasuloPkg::tagWidth-1:0] tag;
    logic [tomasuloPkg::dataWidth-1:0] data;

    // the producer also snoops its own broadcast
    modport producer (output valid, tag, data);

    modport listener (input valid, tag, data);

endinterface

`default_nettype wire

//--- source/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
    input  wire clk,
    input  wire arstN,
    input  wire instValid,
    input  wire tomasuloPkg::instWord inst,
    input  wire stall,
    dispatchIf.decoder disp,
    cdbIf.listener cdb,
    output logic [tomasuloPkg::regWidth-1:0] regAddr1,
    output logic [tomasuloPkg::regWidth-1:0] regAddr2,
    input  wire [tomasuloPkg::tagWidth-1:0] regTag1,
    input  wire [tomasuloPkg::tagWidth-1:0] regTag2,
    input  wire [tomasuloPkg::dataWidth-1:0] regData1,
    input  wire [tomasuloPkg::dataWidth-1:0] regData2,
    output logic tagSet,
    output logic [tomasuloPkg::regWidth-1:0] tagSetAddr,
    output logic [tomasuloPkg::tagWidth-1:0] tagSetTag,
    output logic robAlloc,
    output logic [tomasuloPkg::regWidth-1:0] robDest,
    input  wire [tomasuloPkg::tagWidth-1:0] robTail,
    input  wire [tomasuloPkg::dataWidth-1:0] robData1,
    input  wire [tomasuloPkg::dataWidth-1:0] robData2,
    input  wire robReady1,
    input  wire robReady2
);

    logic isImm;
    logic opValid;
    logic accept;
    logic [2:0] funct3;
    logic [tomasuloPkg::regWidth-1:0] rd;
    logic [tomasuloPkg::aluOpWidth-1:0] aluOp;
    logic [tomasuloPkg::dataWidth-1:0] immExt;
    logic [tomasuloPkg::tagWidth-1:0] tag1;
    logic [tomasuloPkg::tagWidth-1:0] tag2;
    logic [tomasuloPkg::dataWidth-1:0] data1;
    logic [tomasuloPkg::dataWidth-1:0] data2;

    // pending tag set first, then register, reorder buffer, bus
    function automatic logic [tomasuloPkg::tagWidth+tomasuloPkg::dataWidth-1:0] resolve(
        input logic [tomasuloPkg::regWidth-1:0] addr,
        input logic [tomasuloPkg::tagWidth-1:0] tag,
        input logic [tomasuloPkg::dataWidth-1:0] regData,
        input logic robReady,
        input logic [tomasuloPkg::dataWidth-1:0] robData
    );
        if (tagSet && tagSetAddr == addr)
            return {tagSetTag, {tomasuloPkg::dataWidth{1'b0}}};
        if (tag == tomasuloPkg::tagFree)
            return {tomasuloPkg::tagFree, regData};
        if (robReady)
            return {tomasuloPkg::tagFree, robData};
        if (cdb.valid && cdb.tag == tag)
            return {tomasuloPkg::tagFree, cdb.data};
        return {tag, {tomasuloPkg::dataWidth{1'b0}}};
    endfunction

    assign isImm = inst.iType.opcode == tomasuloPkg::classRI;
    assign opValid = (isImm || inst.rType.opcode == tomasuloPkg::classRR) &&
                     inst != tomasuloPkg::nopInst;
    assign accept = instValid && !stall && opValid;
    // funct3, rd and rs1 sit on the same bits in both views
    assign funct3 = inst.rType.funct3;
    assign rd = inst.rType.rd;
    assign regAddr1 = inst.rType.rs1;
    assign regAddr2 = isImm ? '0 : inst.rType.rs2;
    assign immExt = {{(tomasuloPkg::dataWidth-12){inst.iType.imm[11]}}, inst.iType.imm};

    always_comb begin
        case (funct3)
            3'd0: aluOp = (!isImm && inst.rType.funct7[5]) ? tomasuloPkg::opSub
                                                           : tomasuloPkg::opAdd;
            3'd1: aluOp = tomasuloPkg::opSll;
            3'd2: aluOp = tomasuloPkg::opSlt;
            3'd3: aluOp = tomasuloPkg::opSltu;
            3'd4: aluOp = tomasuloPkg::opXor;
            // same bit as imm[10] for the immediate shifts
            3'd5: aluOp = inst.rType.funct7[5] ? tomasuloPkg::opSra : tomasuloPkg::opSrl;
            3'd6: aluOp = tomasuloPkg::opOr;
            default: aluOp = tomasuloPkg::opAnd;
        endcase
    end

    assign {tag1, data1} = resolve(regAddr1, regTag1, regData1, robReady1, robData1);
    assign {tag2, data2} = isImm ? {tomasuloPkg::tagFree, immExt}
                                 : resolve(regAddr2, regTag2, regData2, robReady2, robData2);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            disp.valid <= 1'b0;
            disp.destTag <= tomasuloPkg::tagFree;
            disp.tag1 <= tomasuloPkg::tagFree;
            disp.tag2 <= tomasuloPkg::tagFree;
            robAlloc <= 1'b0;
            tagSet <= 1'b0;
            tagSetTag <= tomasuloPkg::tagFree;
        end else begin
            disp.valid <= accept;
            robAlloc <= accept;
            // x0 keeps no rename tag
            tagSet <= accept && rd != '0;
            if (accept) begin
                disp.destTag <= robTail;
                disp.tag1 <= tag1;
                disp.tag2 <= tag2;
                tagSetTag <= robTail;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            disp.op <= aluOp;
            disp.data1 <= data1;
            disp.data2 <= data2;
            robDest <= rd;
            tagSetAddr <= rd;
        end
    end

endmodule

`default_nettype wire

//--- source/regStatusFile.sv
`timescale 1ns/1ps
`default_nettype none

module regStatusFile (
    input  wire clk,
    input  wire arstN,
    input  wire [tomasuloPkg::regWidth-1:0] regAddr1,
    input  wire [tomasuloPkg::regWidth-1:0] regAddr2,
    output logic [tomasuloPkg::tagWidth-1:0] regTag1,
    output logic [tomasuloPkg::tagWidth-1:0] regTag2,
    output logic [tomasuloPkg::dataWidth-1:0] regData1,
    output logic [tomasuloPkg::dataWidth-1:0] regData2,
    input  wire tagSet,
    input  wire [tomasuloPkg::regWidth-1:0] tagSetAddr,
    input  wire [tomasuloPkg::tagWidth-1:0] tagSetTag,
    input  wire commit,
    input  wire [tomasuloPkg::regWidth-1:0] commitReg,
    input  wire [tomasuloPkg::dataWidth-1:0] commitData,
    input  wire [tomasuloPkg::tagWidth-1:0] commitTag
);

    logic [tomasuloPkg::dataWidth-1:0] values [32];
    logic [tomasuloPkg::tagWidth-1:0] tags [32];

    // x0 is hardwired
    assign regTag1 = (regAddr1 == '0) ? tomasuloPkg::tagFree : tags[regAddr1];
    assign regTag2 = (regAddr2 == '0) ? tomasuloPkg::tagFree : tags[regAddr2];
    assign regData1 = (regAddr1 == '0) ? '0 : values[regAddr1];
    assign regData2 = (regAddr2 == '0) ? '0 : values[regAddr2];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                values[i] <= '0;
                tags[i] <= tomasuloPkg::tagFree;
            end
        end else begin
            if (commit && commitReg != '0)
                values[commitReg] <= commitData;
            // a newer rename on the same register wins over the commit
            if (tagSet)
                tags[tagSetAddr] <= tagSetTag;
            if (commit && tags[commitReg] == commitTag &&
                    !(tagSet && tagSetAddr == commitReg))
                tags[commitReg] <= tomasuloPkg::tagFree;
        end
    end

endmodule

`default_nettype wire

//--- source/reorderBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer (
    input  wire clk,
    input  wire arstN,
    input  wire alloc,
    input  wire [tomasuloPkg::regWidth-1:0] allocDest,
    output logic [tomasuloPkg::tagWidth-1:0] tail,
    output logic full,
    cdbIf.listener cdb,
    input  wire [tomasuloPkg::tagWidth-1:0] lookTag1,
    input  wire [tomasuloPkg::tagWidth-1:0] lookTag2,
    output logic [tomasuloPkg::dataWidth-1:0] lookData1,
    output logic [tomasuloPkg::dataWidth-1:0] lookData2,
    output logic lookReady1,
    output logic lookReady2,
    output logic commitValid,
    output logic [tomasuloPkg::regWidth-1:0] commitReg,
    output logic [tomasuloPkg::dataWidth-1:0] commitData,
    output logic [tomasuloPkg::tagWidth-1:0] commitTag
);

    logic [tomasuloPkg::robIdxWidth-1:0] headIdx;
    logic [tomasuloPkg::robIdxWidth-1:0] tailIdx;
    logic [tomasuloPkg::robIdxWidth-1:0] nextIdx;
    logic [tomasuloPkg::robIdxWidth-1:0] cdbIdx;
    logic [tomasuloPkg::robIdxWidth-1:0] lookIdx1;
    logic [tomasuloPkg::robIdxWidth-1:0] lookIdx2;
    logic [tomasuloPkg::tagWidth-1:0] count;
    logic [tomasuloPkg::robDepth-1:0] done;
    logic [tomasuloPkg::regWidth-1:0] dest [tomasuloPkg::robDepth];
    logic [tomasuloPkg::dataWidth-1:0] value [tomasuloPkg::robDepth];

    // tags 1..8 name entries 0..7
    function automatic logic [tomasuloPkg::robIdxWidth-1:0] toIdx(
        input logic [tomasuloPkg::tagWidth-1:0] tag
    );
        logic [tomasuloPkg::tagWidth-1:0] shifted;
        shifted = tag - 1'b1;
        return shifted[tomasuloPkg::robIdxWidth-1:0];
    endfunction

    assign cdbIdx = toIdx(cdb.tag);
    assign lookIdx1 = toIdx(lookTag1);
    assign lookIdx2 = toIdx(lookTag2);
    assign lookReady1 = lookTag1 != tomasuloPkg::tagFree && done[lookIdx1];
    assign lookReady2 = lookTag2 != tomasuloPkg::tagFree && done[lookIdx2];
    assign lookData1 = value[lookIdx1];
    assign lookData2 = value[lookIdx2];

    // next free slot, past any allocation still in flight
    assign nextIdx = tailIdx + alloc;
    assign tail = {1'b0, nextIdx} + 1'b1;
    assign full = count >= tomasuloPkg::robDepth - 1;

    assign commitValid = count != '0 && done[headIdx];
    assign commitReg = dest[headIdx];
    assign commitData = value[headIdx];
    assign commitTag = {1'b0, headIdx} + 1'b1;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headIdx <= '0;
            tailIdx <= '0;
            count <= '0;
            done <= '0;
        end else begin
            if (alloc)
                tailIdx <= tailIdx + 1'b1;
            if (cdb.valid)
                done[cdbIdx] <= 1'b1;
            // clearing on retire keeps stale slots from forwarding
            if (commitValid) begin
                headIdx <= headIdx + 1'b1;
                done[headIdx] <= 1'b0;
            end
            case ({alloc, commitValid})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc)
            dest[tailIdx] <= allocDest;
        if (cdb.valid)
            value[cdbIdx] <= cdb.data;
    end

endmodule

`default_nettype wire

//--- source/aluStation.sv
`timescale 1ns/1ps
`default_nettype none

module aluStation (
    input  wire clk,
    input  wire arstN,
    dispatchIf.station disp,
    cdbIf.producer cdb,
    output logic almostFull
);

    logic [tomasuloPkg::stationDepth-1:0] valid;
    logic [tomasuloPkg::stationDepth-1:0] snoop1;
    logic [tomasuloPkg::stationDepth-1:0] snoop2;
    logic [tomasuloPkg::stationIdxWidth-1:0] age [tomasuloPkg::stationDepth];
    logic [tomasuloPkg::tagWidth-1:0] destTag [tomasuloPkg::stationDepth];
    logic [tomasuloPkg::aluOpWidth-1:0] op [tomasuloPkg::stationDepth];
    logic [tomasuloPkg::tagWidth-1:0] tag1 [tomasuloPkg::stationDepth];
    logic [tomasuloPkg::tagWidth-1:0] tag2 [tomasuloPkg::stationDepth];
    logic [tomasuloPkg::dataWidth-1:0] data1 [tomasuloPkg::stationDepth];
    logic [tomasuloPkg::dataWidth-1:0] data2 [tomasuloPkg::stationDepth];
    logic [tomasuloPkg::stationIdxWidth:0] numValid;
    logic [tomasuloPkg::stationIdxWidth-1:0] freeIdx;
    logic [tomasuloPkg::stationIdxWidth-1:0] sel;
    logic issueHit;
    logic dispHit1;
    logic dispHit2;
    logic [tomasuloPkg::dataWidth-1:0] opA;
    logic [tomasuloPkg::dataWidth-1:0] opB;
    logic [tomasuloPkg::dataWidth-1:0] result;

    // age counts the older entries, so 0 is the oldest
    always_comb begin
        numValid = '0;
        freeIdx = '0;
        issueHit = 1'b0;
        sel = '0;
        for (int i = tomasuloPkg::stationDepth - 1; i >= 0; i--) begin
            snoop1[i] = valid[i] && cdb.valid && tag1[i] == cdb.tag;
            snoop2[i] = valid[i] && cdb.valid && tag2[i] == cdb.tag;
            if (!valid[i])
                freeIdx = tomasuloPkg::stationIdxWidth'(i);
            else
                numValid = numValid + 1'b1;
        end
        for (int i = 0; i < tomasuloPkg::stationDepth; i++) begin
            if (valid[i] && tag1[i] == tomasuloPkg::tagFree &&
                    tag2[i] == tomasuloPkg::tagFree && (!issueHit || age[i] < age[sel])) begin
                issueHit = 1'b1;
                sel = tomasuloPkg::stationIdxWidth'(i);
            end
        end
    end

    assign almostFull = numValid >= tomasuloPkg::stationDepth - 1;
    assign dispHit1 = cdb.valid && disp.tag1 == cdb.tag;
    assign dispHit2 = cdb.valid && disp.tag2 == cdb.tag;
    assign opA = data1[sel];
    assign opB = data2[sel];

    always_comb begin
        case (op[sel])
            tomasuloPkg::opAdd: result = opA + opB;
            tomasuloPkg::opSub: result = opA - opB;
            tomasuloPkg::opSll: result = opA << opB[4:0];
            tomasuloPkg::opSlt: result = {31'b0, $signed(opA) < $signed(opB)};
            tomasuloPkg::opSltu: result = {31'b0, opA < opB};
            tomasuloPkg::opXor: result = opA ^ opB;
            tomasuloPkg::opSrl: result = opA >> opB[4:0];
            tomasuloPkg::opSra: result = $signed(opA) >>> opB[4:0];
            tomasuloPkg::opOr: result = opA | opB;
            default: result = opA & opB;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            valid <= '0;
            cdb.valid <= 1'b0;
            cdb.tag <= tomasuloPkg::tagFree;
            for (int i = 0; i < tomasuloPkg::stationDepth; i++) begin
                age[i] <= '0;
                destTag[i] <= tomasuloPkg::tagFree;
                tag1[i] <= tomasuloPkg::tagFree;
                tag2[i] <= tomasuloPkg::tagFree;
            end
        end else begin
            cdb.valid <= issueHit;
            cdb.tag <= issueHit ? destTag[sel] : tomasuloPkg::tagFree;
            for (int i = 0; i < tomasuloPkg::stationDepth; i++) begin
                if (snoop1[i])
                    tag1[i] <= tomasuloPkg::tagFree;
                if (snoop2[i])
                    tag2[i] <= tomasuloPkg::tagFree;
                if (issueHit && age[i] > age[sel])
                    age[i] <= age[i] - 1'b1;
            end
            if (issueHit)
                valid[sel] <= 1'b0;
            if (disp.valid) begin
                valid[freeIdx] <= 1'b1;
                age[freeIdx] <= tomasuloPkg::stationIdxWidth'(numValid - issueHit);
                destTag[freeIdx] <= disp.destTag;
                tag1[freeIdx] <= dispHit1 ? tomasuloPkg::tagFree : disp.tag1;
                tag2[freeIdx] <= dispHit2 ? tomasuloPkg::tagFree : disp.tag2;
            end
        end
    end

    always_ff @(posedge clk) begin
        cdb.data <= result;
        for (int i = 0; i < tomasuloPkg::stationDepth; i++) begin
            if (snoop1[i])
                data1[i] <= cdb.data;
            if (snoop2[i])
                data2[i] <= cdb.data;
        end
        if (disp.valid) begin
            op[freeIdx] <= disp.op;
            data1[freeIdx] <= dispHit1 ? cdb.data : disp.data1;
            data2[freeIdx] <= dispHit2 ? cdb.data : disp.data2;
        end
    end

endmodule

`default_nettype wire

//--- source/intCore.sv
`timescale 1ns/1ps
`default_nettype none

module intCore (
    input  wire clk,
    input  wire arstN,
    input  wire instValid,
    input  wire [31:0] inst,
    output logic stall,
    output logic commitValid,
    output logic [tomasuloPkg::regWidth-1:0] commitReg,
    output logic [tomasuloPkg::dataWidth-1:0] commitData
);

    logic [tomasuloPkg::regWidth-1:0] regAddr1;
    logic [tomasuloPkg::regWidth-1:0] regAddr2;
    logic [tomasuloPkg::tagWidth-1:0] regTag1;
    logic [tomasuloPkg::tagWidth-1:0] regTag2;
    logic [tomasuloPkg::dataWidth-1:0] regData1;
    logic [tomasuloPkg::dataWidth-1:0] regData2;
    logic tagSet;
    logic [tomasuloPkg::regWidth-1:0] tagSetAddr;
    logic [tomasuloPkg::tagWidth-1:0] tagSetTag;
    logic robAlloc;
    logic [tomasuloPkg::regWidth-1:0] robDest;
    logic [tomasuloPkg::tagWidth-1:0] robTail;
    logic [tomasuloPkg::dataWidth-1:0] robData1;
    logic [tomasuloPkg::dataWidth-1:0] robData2;
    logic robReady1;
    logic robReady2;
    logic robFull;
    logic stationFull;
    logic [tomasuloPkg::tagWidth-1:0] commitTag;

    dispatchIf dispatch ();
    cdbIf cdb ();

    instDecoder instInstDecoder (
        .clk(clk), .arstN(arstN), .instValid(instValid), .inst(inst), .stall(stall),
        .disp(dispatch.decoder), .cdb(cdb.listener),
        .regAddr1(regAddr1), .regAddr2(regAddr2), .regTag1(regTag1), .regTag2(regTag2),
        .regData1(regData1), .regData2(regData2),
        .tagSet(tagSet), .tagSetAddr(tagSetAddr), .tagSetTag(tagSetTag),
        .robAlloc(robAlloc), .robDest(robDest), .robTail(robTail),
        .robData1(robData1), .robData2(robData2), .robReady1(robReady1), .robReady2(robReady2)
    );

    regStatusFile instRegStatusFile (
        .clk(clk), .arstN(arstN), .regAddr1(regAddr1), .regAddr2(regAddr2),
        .regTag1(regTag1), .regTag2(regTag2), .regData1(regData1), .regData2(regData2),
        .tagSet(tagSet), .tagSetAddr(tagSetAddr), .tagSetTag(tagSetTag),
        .commit(commitValid), .commitReg(commitReg), .commitData(commitData),
        .commitTag(commitTag)
    );

    // lookups follow the rename tags straight from the status file
    reorderBuffer instReorderBuffer (
        .clk(clk), .arstN(arstN), .alloc(robAlloc), .allocDest(robDest),
        .tail(robTail), .full(robFull), .cdb(cdb.listener),
        .lookTag1(regTag1), .lookTag2(regTag2), .lookData1(robData1), .lookData2(robData2),
        .lookReady1(robReady1), .lookReady2(robReady2),
        .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData),
        .commitTag(commitTag)
    );

    aluStation instAluStation (
        .clk(clk), .arstN(arstN), .disp(dispatch.station), .cdb(cdb.producer),
        .almostFull(stationFull)
    );

    assign stall = robFull | stationFull;

endmodule

`default_nettype wire

//--- sim/intCore_props.sv
`timescale 1ns/1ps
`default_nettype none

module intCore_props (
    input wire clk,
    input wire arstN,
    input wire alloc,
    input wire commitValid,
    input wire cdbValid,
    input wire [tomasuloPkg::robIdxWidth-1:0] cdbIdx,
    input wire [tomasuloPkg::tagWidth-1:0] count,
    input wire [tomasuloPkg::robIdxWidth-1:0] headIdx,
    input wire [tomasuloPkg::robIdxWidth-1:0] tailIdx
);

    logic [tomasuloPkg::robDepth-1:0] resultSeen;

    // result broadcast since the slot was last allocated
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultSeen <= '0;
        end else begin
            if (alloc)
                resultSeen[tailIdx] <= 1'b0;
            if (cdbValid)
                resultSeen[cdbIdx] <= 1'b1;
        end
    end

    countBound: assert property (@(posedge clk) disable iff (!arstN)
        count <= tomasuloPkg::robDepth)
        else $error("reorder buffer holds %0d entries, more than its depth", count);

    // an allocation always finds a free slot
    allocRoom: assert property (@(posedge clk) disable iff (!arstN)
        alloc |-> count < tomasuloPkg::robDepth)
        else $error("allocation while the reorder buffer is full");

    commitDone: assert property (@(posedge clk) disable iff (!arstN)
        commitValid |-> resultSeen[headIdx])
        else $error("commit of a head entry whose result never reached the bus");

    quietAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !commitValid)
        else $error("commit strobe high right after reset release");

endmodule

bind reorderBuffer intCore_props robProps (
    .clk(clk), .arstN(arstN), .alloc(alloc), .commitValid(commitValid),
    .cdbValid(cdb.valid), .cdbIdx(cdbIdx), .count(count), .headIdx(headIdx),
    .tailIdx(tailIdx)
);

`default_nettype wire

//--- sim/intCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module intCore_tb;

    localparam int waitLimit = 200;
    localparam int streamLength = 400;

    logic clk;
    logic arstN;
    logic instValid;
    logic [31:0] inst;
    logic stall;
    logic commitValid;
    logic [4:0] commitReg;
    logic [31:0] commitData;

    logic [31:0] modelRegs [32];
    logic [4:0] expReg [$];
    logic [31:0] expData [$];
    bit stallSeen;

    intCore u_dut (
        .clk(clk), .arstN(arstN), .instValid(instValid), .inst(inst), .stall(stall),
        .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData)
    );

    always #5 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // RV32I integer result, shift amount from the low five bits
    function automatic logic [31:0] refResult(input logic [31:0] word,
        input logic [31:0] a, input logic [31:0] b);
        logic alt;
        alt = word[30];
        case (word[14:12])
            3'd0: begin
                if (alt && word[6:0] == 7'b0110011)
                    return a - b;
                return a + b;
            end
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] randomWord();
        int kind;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        kind = $urandom_range(0, 19);
        f3 = 3'($urandom_range(0, 7));
        rd = 5'($urandom_range(0, 7));
        rs1 = 5'($urandom_range(0, 7));
        rs2 = 5'($urandom_range(0, 7));
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) != 0) ? 7'h20 : 7'h00;
        imm = 12'($urandom);
        if (f3 == 3'd1 || f3 == 3'd5)
            imm = {f7, 5'($urandom_range(0, 31))};
        if (kind < 9)
            return rTypeWord(f7, rs2, rs1, f3, rd);
        if (kind < 17)
            return iTypeWord(imm, rs1, f3, rd);
        if (kind == 17)
            return 32'h0000_0013;
        // load, store, branch or lui, all dropped
        case ($urandom_range(0, 3))
            0: return {25'($urandom), 7'b0000011};
            1: return {25'($urandom), 7'b0100011};
            2: return {25'($urandom), 7'b1100011};
            default: return {25'($urandom), 7'b0110111};
        endcase
    endfunction

    // in-order execution at acceptance
    task automatic applyToModel(input logic [31:0] word);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = modelRegs[word[19:15]];
        if (word[6:0] == 7'b0010011)
            b = {{20{word[31]}}, word[31:20]};
        else
            b = modelRegs[word[24:20]];
        if ((word[6:0] == 7'b0010011 || word[6:0] == 7'b0110011) && word != 32'h0000_0013) begin
            res = refResult(word, a, b);
            if (word[11:7] != 5'd0)
                modelRegs[word[11:7]] = res;
            expReg.push_back(word[11:7]);
            expData.push_back(res);
        end
    endtask

    // holds the word until an edge takes it with stall low
    task automatic sendWord(input logic [31:0] word);
        int cycles;
        bit taken;
        cycles = 0;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            instValid <= 1'b1;
            inst <= word;
            @(negedge clk);
            if (!stall) begin
                taken = 1'b1;
                applyToModel(word);
            end else begin
                @(posedge clk);
                instValid <= 1'b0;
                do begin
                    @(negedge clk);
                    cycles++;
                    if (cycles > waitLimit)
                        abortRun("stall stayed high too long, the core stopped taking words");
                end while (stall);
            end
        end
    endtask

    task automatic idleCycle();
        @(posedge clk);
        instValid <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (arstN && stall)
            stallSeen = 1'b1;
        if (arstN && commitValid) begin
            assert (expReg.size() != 0)
                else abortRun("a commit arrived with no instruction outstanding");
            if (expReg.size() != 0) begin
                assert (commitReg == expReg[0])
                    else abortRun($sformatf("FAIL %0t commitReg expected %0d actual %0d",
                        $time, expReg[0], commitReg));
                assert (commitData == expData[0])
                    else abortRun($sformatf("FAIL %0t commitData expected %h actual %h",
                        $time, expData[0], commitData));
                void'(expReg.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'h56c4));
        clk = 1'b0;
        arstN = 1'b0;
        instValid = 1'b0;
        inst = 32'h0;
        stallSeen = 1'b0;
        for (int r = 0; r < 32; r++)
            modelRegs[r] = '0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;

        // large and negative operands, funct7 selection, x0 writes
        sendWord(iTypeWord(12'hfff, 5'd0, 3'd0, 5'd1));
        sendWord(iTypeWord({7'h00, 5'd31}, 5'd1, 3'd1, 5'd2));
        sendWord(iTypeWord(12'd37, 5'd0, 3'd0, 5'd3));
        sendWord(rTypeWord(7'h20, 5'd3, 5'd2, 3'd5, 5'd4));
        sendWord(rTypeWord(7'h00, 5'd3, 5'd2, 3'd5, 5'd5));
        sendWord(rTypeWord(7'h20, 5'd1, 5'd2, 3'd0, 5'd6));
        sendWord(iTypeWord({7'h20, 5'd4}, 5'd1, 3'd5, 5'd7));
        sendWord(rTypeWord(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
        sendWord(rTypeWord(7'h00, 5'd1, 5'd0, 3'd0, 5'd6));

        for (int i = 0; i < streamLength; i++) begin
            if ($urandom_range(0, 9) == 0)
                idleCycle();
            else
                sendWord(randomWord());
        end
        idleCycle();

        cycles = 0;
        while (expReg.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > waitLimit)
                abortRun("outstanding instructions never committed");
        end
        // any late commit here trips the checker
        repeat (8) @(negedge clk);

        if (stallSeen) begin
            $display("** PASS **");
            $finish;
        end else begin
            abortRun("stall never rose during the instruction bursts");
        end
    end

endmodule

`default_nettype wire

//--- intCore.f
source/tomasuloPkg.sv
source/dispatchIf.sv
source/cdbIf.sv
source/instDecoder.sv
source/regStatusFile.sv
source/reorderBuffer.sv
source/aluStation.sv
source/intCore.sv
sim/intCore_props.sv
sim/intCore_tb.sv
